//--- Makefile
SIM = obj_dir/Vqroute_tb

.PHONY: compile run clean

compile: $(SIM)

$(SIM): qroute.f source/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module qroute_tb \
		-f qroute.f -o Vqroute_tb

# a crashed or stopped run counts as a failure
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
	cat sim.log
	! grep -q ">>> FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/qroute_checker.sv
`timescale 1ns/1ps

module qroute_checker (
	input  logic        clock,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] prdata,
	input  logic        pready,
	input  logic [31:0] exp_config,
	input  logic [31:0] exp_busy_word,
	input  logic [31:0] exp_final_word,
	input  logic        expect_stall,
	output int          error_count,
	output int          check_count
);
	import qroute_pkg::*;

	int          errors = 0;
	int          checks = 0;
	logic        waited = 1'b0;
	logic [31:0] expected;

	assign error_count = errors;
	assign check_count = checks;

	// sampled on the completing edge, before the dut registers update
	always @(posedge clock) begin
		if (rst) begin
			waited = 1'b0;
		end else if (psel && penable && !pready) begin
			// only a message write may wait
			waited = 1'b1;
			if (!(pwrite && paddr == reg_message)) begin
				errors++;
				$display("Read or config write stalled at %0t ns", $time);
			end
		end else if (psel && penable) begin
			if (pwrite && paddr == reg_message && expect_stall) begin
				checks++;
				if (!waited) begin
					errors++;
					$display("Message write at %0t ns did not wait for the busy engine", $time);
				end
			end
			if (!pwrite && paddr == reg_result) begin
				// busy reads keep the old result, done clear
				expected = prdata[31] ? exp_busy_word : exp_final_word;
				checks++;
				if (prdata !== expected) begin
					errors++;
					$display("Error at %0t ns: result read %h, expected %h", $time, prdata, expected);
				end
			end
			if (!pwrite && paddr == reg_config) begin
				checks++;
				if (prdata !== exp_config) begin
					errors++;
					$display("Error at %0t ns: config read %h, expected %h", $time, prdata, exp_config);
				end
			end
			waited = 1'b0;
		end
	end

endmodule

//--- bench/qroute_props.sv
`timescale 1ns/1ps

module qroute_props (
	input logic       clock,
	input logic       rst,
	input logic       psel,
	input logic       penable,
	input logic       pwrite,
	input logic [3:0] paddr,
	input logic       pready,
	input logic       msg_start,
	input logic       learn_done,
	input logic       search_done,
	input logic       policy_done
);
	import qroute_pkg::*;

	logic msg_wr;
	int   fail_count = 0;

	// message write, setup or access phase
	assign msg_wr = psel && pwrite && (paddr == reg_message);

	// access phase only inside a selected transfer
	penable_needs_psel: assert property (@(posedge clock) disable iff (rst)
		penable |-> psel)
		else begin
			$error("penable high without psel");
			fail_count++;
		end

	// setup phase is always followed by the access phase
	setup_then_access: assert property (@(posedge clock) disable iff (rst)
		psel && !penable |=> psel && penable)
		else begin
			$error("setup phase not followed by access phase");
			fail_count++;
		end

	// stalled transfer holds until pready
	held_while_waiting: assert property (@(posedge clock) disable iff (rst)
		psel && penable && !pready |=> psel && penable)
		else begin
			$error("transfer dropped while pready low");
			fail_count++;
		end

	// stage handshakes are single-cycle pulses
	start_one_cycle: assert property (@(posedge clock) disable iff (rst)
		msg_start |=> !msg_start)
		else begin
			$error("msg_start longer than one cycle");
			fail_count++;
		end
	learn_one_cycle: assert property (@(posedge clock) disable iff (rst)
		learn_done |=> !learn_done)
		else begin
			$error("learn_done longer than one cycle");
			fail_count++;
		end
	search_one_cycle: assert property (@(posedge clock) disable iff (rst)
		search_done |=> !search_done)
		else begin
			$error("search_done longer than one cycle");
			fail_count++;
		end
	policy_one_cycle: assert property (@(posedge clock) disable iff (rst)
		policy_done |=> !policy_done)
		else begin
			$error("policy_done longer than one cycle");
			fail_count++;
		end

	// stalled write released only right after a stage done pulse
	busy_ends_on_done: assert property (@(posedge clock) disable iff (rst)
		msg_wr && pready && $past(msg_wr && !pready) |-> $past(learn_done || policy_done))
		else begin
			$error("engine left busy without a done pulse");
			fail_count++;
		end

endmodule

//--- bench/qroute_tb.sv
`timescale 1ns/1ps

module qroute_tb;
	import qroute_pkg::*;

	localparam int alpha_shift   = 2;
	localparam int table_depth   = 16;
	localparam int num_random    = 160;
	localparam int directed_msgs = 30;
	// 40 cycles per message, margin for reset and config
	localparam int limit_cycles  = (num_random + directed_msgs) * 40 + 200;

	logic        clock;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;

	// expectations for the checker
	logic [31:0] exp_config;
	logic [31:0] exp_busy_word;
	logic [31:0] exp_final_word;
	logic        expect_stall;
	int          error_count;
	int          check_count;

	// reference model state
	logic [31:0] rng;
	logic [15:0] hop_lfsr;
	logic        tbl_valid [table_depth];
	logic [3:0]  tbl_cluster [table_depth];
	logic [15:0] tbl_q [table_depth];
	logic [3:0]  my_id;
	logic [3:0]  my_cluster;
	logic [7:0]  epsilon;
	logic [1:0]  last_action;
	logic [3:0]  last_hop;

	qroute_top #(.alpha_shift(alpha_shift), .table_depth(table_depth)) dut (
		.clock, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready
	);

	qroute_checker u_check (
		.clock, .rst, .psel, .penable, .pwrite, .paddr, .prdata, .pready,
		.exp_config, .exp_busy_word, .exp_final_word, .expect_stall,
		.error_count, .check_count
	);

	bind qroute_top qroute_props u_props (
		.clock(clock), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pready(pready), .msg_start(msg_start),
		.learn_done(learn_done), .search_done(search_done), .policy_done(policy_done)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// watchdog
	initial begin
		repeat (limit_cycles) @(posedge clock);
		$display("Timeout: test did not finish within %0d cycles", limit_cycles);
		$display(">>> FAIL");
		$finish;
	end

	// stimulus source, 32-bit galois, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			rng = (rng >> 1) ^ (rng[0] ? 32'h8020_0003 : 32'h0);
			v = {v[30:0], rng[0]};
		end
		return v;
	endfunction

	// blend rule: seed on first report, else q - q>>a + cost>>a, saturating
	task automatic learn_cost(input logic [3:0] id, input logic [3:0] cl,
			input logic [15:0] cost);
		logic [16:0] sum;
		if (!tbl_valid[id]) begin
			tbl_q[id] = cost;
		end else begin
			sum = 17'(tbl_q[id]) - 17'(tbl_q[id] >> alpha_shift) + 17'(cost >> alpha_shift);
			tbl_q[id] = sum[16] ? 16'hFFFF : sum[15:0];
		end
		tbl_cluster[id] = cl;
		tbl_valid[id] = 1'b1;
	endtask

	// cheapest in-cluster neighbor, then epsilon-greedy and action
	task automatic route_model(input logic [3:0] dest, output logic [1:0] act,
			output logic [3:0] hop);
		logic       best_ok;
		logic [3:0] best;
		logic [15:0] best_cost;
		logic [3:0] probe;
		logic       explore;
		int i;
		best_ok = 1'b0;
		best = '0;
		best_cost = '0;
		for (i = 0; i < table_depth; i++) begin
			// strict compare, ties stay with the lower index
			if (tbl_valid[i] && tbl_cluster[i] == my_cluster
					&& (!best_ok || tbl_q[i] < best_cost)) begin
				best_ok = 1'b1;
				best = 4'(i);
				best_cost = tbl_q[i];
			end
		end
		// stepped on every request, deliver too
		hop_lfsr = (hop_lfsr >> 1) ^ (hop_lfsr[0] ? lfsr_taps : 16'h0);
		probe = hop_lfsr[11:8];
		explore = (hop_lfsr[7:0] < epsilon) && tbl_valid[probe]
			&& (tbl_cluster[probe] == my_cluster);
		if (dest == my_id) begin
			act = act_deliver;
			hop = my_id;
		end else if (explore) begin
			act = act_forward;
			hop = probe;
		end else if (best_ok) begin
			act = act_forward;
			hop = best;
		end else begin
			act = act_drop;
			hop = '0;
		end
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		@(negedge clock);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		penable = 1'b0;
		@(negedge clock);
		penable = 1'b1;
		@(posedge clock);
		while (!pready) begin
			@(posedge clock);
		end
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
		@(negedge clock);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		penable = 1'b0;
		@(negedge clock);
		penable = 1'b1;
		@(posedge clock);
		while (!pready) begin
			@(posedge clock);
		end
		data = prdata;
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic set_config(input logic [3:0] id, input logic [3:0] cl,
			input logic [7:0] eps);
		my_id = id;
		my_cluster = cl;
		epsilon = eps;
		exp_config = {16'h0, eps, cl, id};
		apb_write(reg_config, {16'h0, eps, cl, id});
	endtask

	// result fields do not move on an update
	task automatic write_update(input logic [3:0] id, input logic [3:0] cl,
			input logic [15:0] cost);
		exp_busy_word = {2'b10, 12'h0, last_action, 12'h0, last_hop};
		exp_final_word = {2'b01, 12'h0, last_action, 12'h0, last_hop};
		learn_cost(id, cl, cost);
		apb_write(reg_message, {1'b1, 7'h0, cost, cl, id});
	endtask

	task automatic write_request(input logic [3:0] dest);
		logic [1:0] act;
		logic [3:0] hop;
		route_model(dest, act, hop);
		exp_busy_word = {2'b10, 12'h0, last_action, 12'h0, last_hop};
		exp_final_word = {2'b01, 12'h0, act, 12'h0, hop};
		last_action = act;
		last_hop = hop;
		apb_write(reg_message, {1'b0, 27'h0, dest});
	endtask

	// poll the result register until busy clears
	task automatic wait_until_done();
		logic [31:0] word;
		apb_read(reg_result, word);
		while (word[31]) begin
			apb_read(reg_result, word);
		end
	endtask

	task automatic update_and_wait(input logic [3:0] id, input logic [3:0] cl,
			input logic [15:0] cost);
		write_update(id, cl, cost);
		wait_until_done();
	endtask

	task automatic request_and_wait(input logic [3:0] dest);
		write_request(dest);
		wait_until_done();
	endtask

	initial begin
		logic [31:0] word;
		logic [3:0]  id;
		logic [3:0]  cl;
		logic [15:0] cost;
		int n;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		exp_config = '0;
		exp_busy_word = '0;
		exp_final_word = '0;
		expect_stall = 1'b0;
		rng = 32'h47c8_5537;
		hop_lfsr = lfsr_seed;
		my_id = '0;
		my_cluster = '0;
		epsilon = '0;
		last_action = '0;
		last_hop = '0;
		for (n = 0; n < table_depth; n++) begin
			tbl_valid[n] = 1'b0;
			tbl_cluster[n] = '0;
			tbl_q[n] = '0;
		end
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;

		// both registers read zero out of reset
		apb_read(reg_result, word);
		apb_read(reg_config, word);
		set_config(4'd5, 4'd3, 8'd0);
		apb_read(reg_config, word);

		// empty table gives drop, own id gives deliver
		request_and_wait(4'd9);
		request_and_wait(4'd5);

		// cheapest in cluster, tie between 4 and 7
		update_and_wait(4'd2, 4'd3, 16'd300);
		update_and_wait(4'd7, 4'd3, 16'd100);
		update_and_wait(4'd4, 4'd3, 16'd100);
		update_and_wait(4'd1, 4'd6, 16'd50);
		update_and_wait(4'd11, 4'd6, 16'd10);
		request_and_wait(4'd12);

		// seed at 20, then blend around the pair at 100
		update_and_wait(4'd9, 4'd3, 16'd20);
		request_and_wait(4'd0);
		// 20 - 5 + 84 lands just under the pair
		update_and_wait(4'd9, 4'd3, 16'd336);
		request_and_wait(4'd0);
		// 99 - 24 + 25 ties the pair, lower index 4 wins
		update_and_wait(4'd9, 4'd3, 16'd100);
		request_and_wait(4'd0);
		// blend toward the maximum cost
		for (n = 0; n < 6; n++) begin
			update_and_wait(4'd9, 4'd3, 16'hFFFF);
		end
		request_and_wait(4'd0);

		// no neighbor in cluster 7
		set_config(4'd5, 4'd7, 8'd0);
		request_and_wait(4'd3);
		request_and_wait(4'd5);
		set_config(4'd5, 4'd3, 8'd0);

		// update queued behind a running request
		write_request(4'd14);
		expect_stall = 1'b1;
		write_update(4'd4, 4'd3, 16'd5000);
		expect_stall = 1'b0;
		wait_until_done();
		request_and_wait(4'd14);

		// random mix, fresh epsilon every 16 messages
		for (n = 0; n < num_random; n++) begin
			if (n % 16 == 0) begin
				set_config(4'd5, 4'd3, 8'(rand_bits(8)));
			end
			if (rand_bits(1) != 0) begin
				id = 4'(rand_bits(4));
				cl = (rand_bits(1) != 0) ? 4'd3 : 4'(rand_bits(4));
				cost = (rand_bits(1) != 0) ? 16'(rand_bits(16)) : 16'(rand_bits(8));
				update_and_wait(id, cl, cost);
			end else begin
				request_and_wait(4'(rand_bits(4)));
			end
		end

		$display("checks: %0d, errors: %0d, assertion failures: %0d", check_count,
			error_count, dut.u_props.fail_count);
		if (error_count == 0 && dut.u_props.fail_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- qroute.f
source/qroute_pkg.sv
source/apb_node_regs.sv
source/neighbor_table.sv
source/cost_learner.sv
source/best_search.sv
source/hop_policy.sv
source/qroute_top.sv
bench/qroute_props.sv
bench/qroute_checker.sv
bench/qroute_tb.sv

//--- source/apb_node_regs.sv
`timescale 1ns/1ps

module apb_node_regs (
	input  logic                             clock,
	input  logic                             rst,
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [3:0]                       paddr,
	input  logic [31:0]                      pwdata,
	output logic [31:0]                      prdata,
	output logic                             pready,
	output logic [qroute_pkg::node_id_w-1:0] my_id,
	output logic [qroute_pkg::cluster_w-1:0] my_cluster,
	output logic [7:0]                       epsilon,
	output logic                             msg_start,
	output logic                             msg_update,
	output logic [qroute_pkg::node_id_w-1:0] msg_id,
	output logic [qroute_pkg::cluster_w-1:0] msg_cluster,
	output logic [qroute_pkg::q_w-1:0]       msg_cost,
	input  logic                             learn_done,
	input  logic                             policy_done,
	input  logic [1:0]                       action,
	input  logic [qroute_pkg::node_id_w-1:0] next_hop
);
	import qroute_pkg::*;

	route_msg_u msg;
	logic       msg_wr;
	logic       msg_accept;
	logic       cfg_wr;
	logic       busy;
	logic       done;
	logic [1:0] res_action;
	logic [node_id_w-1:0] res_hop;

	// incoming word seen through both views
	assign msg = pwdata;

	// message write in setup or access phase
	assign msg_wr = psel && pwrite && (paddr == reg_message);
	// only taken once the engine is free
	assign msg_accept = msg_wr && penable && !busy;
	assign cfg_wr = psel && penable && pwrite && (paddr == reg_config);

	// stall message writes while busy, reads never wait
	assign pready = !(msg_wr && busy);

	// node config
	always_ff @(posedge clock) begin
		if (rst) begin
			my_id      <= '0;
			my_cluster <= '0;
			epsilon    <= '0;
		end else if (cfg_wr) begin
			my_id      <= pwdata[3:0];
			my_cluster <= pwdata[7:4];
			epsilon    <= pwdata[15:8];
		end
	end

	// launch pulse, one cycle
	always_ff @(posedge clock) begin
		if (rst) begin
			msg_start <= 1'b0;
		end else begin
			msg_start <= msg_accept;
		end
	end

	// decoded fields, held until next message
	always_ff @(posedge clock) begin
		if (msg_accept) begin
			msg_update  <= msg.upd.kind;
			// id sits in bits 3:0 for both kinds
			msg_id      <= msg.req.dest_id;
			msg_cluster <= msg.upd.src_cluster;
			msg_cost    <= msg.upd.cost;
		end
	end

	// busy from accept to the stage done pulse
	// done is sticky until the next accept
	always_ff @(posedge clock) begin
		if (rst) begin
			busy       <= 1'b0;
			done       <= 1'b0;
			res_action <= '0;
			res_hop    <= '0;
		end else begin
			if (msg_accept) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (learn_done || policy_done) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			// result only changes on a request
			if (policy_done) begin
				res_action <= action;
				res_hop    <= next_hop;
			end
		end
	end

	// read mux, message register reads as zero
	always_comb begin
		case (paddr)
			reg_config: prdata = {16'h0, epsilon, my_cluster, my_id};
			reg_result: prdata = {busy, done, 12'h0, res_action, 12'h0, res_hop};
			default:    prdata = 32'h0;
		endcase
	end

endmodule

//--- source/best_search.sv
`timescale 1ns/1ps

module best_search #(
	parameter int table_depth = 16
) (
	input  logic                             clock,
	input  logic                             rst,
	input  logic                             msg_start,
	input  logic                             msg_update,
	input  logic [qroute_pkg::cluster_w-1:0] my_cluster,
	output logic [qroute_pkg::node_id_w-1:0] scan_id,
	output logic                             search_done,
	output logic                             best_valid,
	output logic [qroute_pkg::node_id_w-1:0] best_id,
	output logic [qroute_pkg::q_w-1:0]       best_q,
	input  logic                             scan_valid,
	input  logic [qroute_pkg::cluster_w-1:0] scan_cluster,
	input  logic [qroute_pkg::q_w-1:0]       scan_q
);
	import qroute_pkg::*;

	localparam logic [node_id_w-1:0] last_id = node_id_w'(table_depth - 1);

	logic active;
	logic better;

	// in cluster and strictly cheaper, so ties keep the lower index
	assign better = scan_valid && (scan_cluster == my_cluster)
		&& (!best_valid || (scan_q < best_q));

	// scan control
	always_ff @(posedge clock) begin
		if (rst) begin
			active      <= 1'b0;
			search_done <= 1'b0;
			scan_id     <= '0;
			best_valid  <= 1'b0;
		end else begin
			search_done <= 1'b0;
			if (msg_start && !msg_update) begin
				// start cycle, clear the running best
				active     <= 1'b1;
				scan_id    <= '0;
				best_valid <= 1'b0;
			end else if (active) begin
				if (better) begin
					best_valid <= 1'b1;
				end
				if (scan_id == last_id) begin
					active      <= 1'b0;
					search_done <= 1'b1;
				end else begin
					scan_id <= scan_id + 1'b1;
				end
			end
		end
	end

	// running best id and cost
	always_ff @(posedge clock) begin
		if (active && better) begin
			best_id <= scan_id;
			best_q  <= scan_q;
		end
	end

endmodule

//--- source/cost_learner.sv
`timescale 1ns/1ps

module cost_learner #(
	parameter int alpha_shift = 2
) (
	input  logic                             clock,
	input  logic                             rst,
	input  logic                             msg_start,
	input  logic                             msg_update,
	input  logic [qroute_pkg::node_id_w-1:0] msg_id,
	input  logic [qroute_pkg::cluster_w-1:0] msg_cluster,
	input  logic [qroute_pkg::q_w-1:0]       msg_cost,
	output logic [qroute_pkg::node_id_w-1:0] rd_id,
	output logic                             wr_en,
	output logic [qroute_pkg::node_id_w-1:0] wr_id,
	output logic [qroute_pkg::cluster_w-1:0] wr_cluster,
	output logic [qroute_pkg::q_w-1:0]       wr_q,
	output logic                             learn_done,
	input  logic                             rd_valid,
	input  logic [qroute_pkg::q_w-1:0]       rd_q
);
	import qroute_pkg::*;

	logic           write_phase;
	logic [q_w:0]   blend_sum;
	logic [q_w-1:0] new_q;

	// read address straight from the message
	assign rd_id = msg_id;

	// q - q>>a + cost>>a, one spare bit for the carry
	always_comb begin
		blend_sum = {1'b0, rd_q} - {1'b0, rd_q >> alpha_shift}
			+ {1'b0, msg_cost >> alpha_shift};
		if (!rd_valid) begin
			// first report seeds the entry
			new_q = msg_cost;
		end else if (blend_sum[q_w]) begin
			new_q = '1;
		end else begin
			new_q = blend_sum[q_w-1:0];
		end
	end

	// read cycle: start pulse on an update
	always_ff @(posedge clock) begin
		if (rst) begin
			write_phase <= 1'b0;
		end else begin
			write_phase <= msg_start && msg_update;
		end
	end

	// blended entry held for the write cycle
	always_ff @(posedge clock) begin
		if (msg_start && msg_update) begin
			wr_id      <= msg_id;
			wr_cluster <= msg_cluster;
			wr_q       <= new_q;
		end
	end

	// write cycle doubles as the done pulse
	assign wr_en      = write_phase;
	assign learn_done = write_phase;

endmodule

//--- source/hop_policy.sv
`timescale 1ns/1ps

module hop_policy (
	input  logic                             clock,
	input  logic                             rst,
	input  logic                             search_done,
	input  logic                             best_valid,
	input  logic [qroute_pkg::node_id_w-1:0] best_id,
	input  logic [qroute_pkg::node_id_w-1:0] my_id,
	input  logic [7:0]                       epsilon,
	input  logic [qroute_pkg::node_id_w-1:0] msg_id,
	output logic [qroute_pkg::node_id_w-1:0] probe_id,
	input  logic                             probe_valid,
	input  logic [qroute_pkg::cluster_w-1:0] probe_cluster,
	input  logic [qroute_pkg::cluster_w-1:0] my_cluster,
	output logic                             policy_done,
	output logic [1:0]                       action,
	output logic [qroute_pkg::node_id_w-1:0] next_hop
);
	import qroute_pkg::*;

	logic [15:0]          lfsr;
	logic [15:0]          lfsr_next;
	logic                 explore;
	logic [1:0]           pick_action;
	logic [node_id_w-1:0] pick_hop;

	// one galois step, decision uses the stepped value
	assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? lfsr_taps : 16'h0);

	// random neighbor to probe on port b
	assign probe_id = lfsr_next[11:8];

	// explore only onto a live in-cluster neighbor
	assign explore = (lfsr_next[7:0] < epsilon) && probe_valid
		&& (probe_cluster == my_cluster);

	always_comb begin
		if (msg_id == my_id) begin
			// destination reached, lfsr outcome ignored
			pick_action = act_deliver;
			pick_hop    = my_id;
		end else if (explore) begin
			pick_action = act_forward;
			pick_hop    = probe_id;
		end else if (best_valid) begin
			pick_action = act_forward;
			pick_hop    = best_id;
		end else begin
			// nobody usable in the cluster
			pick_action = act_drop;
			pick_hop    = '0;
		end
	end

	// lfsr advances once per request
	always_ff @(posedge clock) begin
		if (rst) begin
			lfsr        <= lfsr_seed;
			policy_done <= 1'b0;
		end else begin
			policy_done <= search_done;
			if (search_done) begin
				lfsr <= lfsr_next;
			end
		end
	end

	// decision registered in the policy cycle
	always_ff @(posedge clock) begin
		if (search_done) begin
			action   <= pick_action;
			next_hop <= pick_hop;
		end
	end

endmodule

//--- source/neighbor_table.sv
`timescale 1ns/1ps

module neighbor_table #(
	parameter int table_depth = 16
) (
	input  logic                             clock,
	input  logic                             rst,
	input  logic                             wr_en,
	input  logic [qroute_pkg::node_id_w-1:0] wr_id,
	input  logic [qroute_pkg::cluster_w-1:0] wr_cluster,
	input  logic [qroute_pkg::q_w-1:0]       wr_q,
	input  logic [qroute_pkg::node_id_w-1:0] rd_a_id,
	input  logic [qroute_pkg::node_id_w-1:0] rd_b_id,
	output logic                             rd_a_valid,
	output logic [qroute_pkg::cluster_w-1:0] rd_a_cluster,
	output logic [qroute_pkg::q_w-1:0]       rd_a_q,
	output logic                             rd_b_valid,
	output logic [qroute_pkg::cluster_w-1:0] rd_b_cluster,
	output logic [qroute_pkg::q_w-1:0]       rd_b_q
);
	import qroute_pkg::*;

	logic [table_depth-1:0] valid;
	logic [cluster_w-1:0]   cluster_mem [table_depth];
	logic [q_w-1:0]         q_mem [table_depth];

	// valid bits, cleared on reset
	always_ff @(posedge clock) begin
		if (rst) begin
			valid <= '0;
		end else if (wr_en) begin
			valid[wr_id] <= 1'b1;
		end
	end

	// entry payload, single write port
	always_ff @(posedge clock) begin
		if (wr_en) begin
			cluster_mem[wr_id] <= wr_cluster;
			q_mem[wr_id]       <= wr_q;
		end
	end

	// port a, learner side
	assign rd_a_valid   = valid[rd_a_id];
	assign rd_a_cluster = cluster_mem[rd_a_id];
	assign rd_a_q       = q_mem[rd_a_id];

	// port b, search and policy side
	assign rd_b_valid   = valid[rd_b_id];
	assign rd_b_cluster = cluster_mem[rd_b_id];
	assign rd_b_q       = q_mem[rd_b_id];

endmodule

//--- source/qroute_pkg.sv
package qroute_pkg;

	// identifier widths, 16 neighbors max
	localparam int node_id_w = 4;
	localparam int cluster_w = 4;

	// q value and reported cost width
	localparam int q_w = 16;

	// apb word offsets
	localparam logic [3:0] reg_config  = 4'h0;
	localparam logic [3:0] reg_message = 4'h4;
	localparam logic [3:0] reg_result  = 4'h8;

	// action codes in the result register
	localparam logic [1:0] act_forward = 2'd0;
	localparam logic [1:0] act_deliver = 2'd1;
	localparam logic [1:0] act_drop    = 2'd2;

	// galois lfsr, right shifting
	localparam logic [15:0] lfsr_taps = 16'hB400;
	localparam logic [15:0] lfsr_seed = 16'hACE1;

	// cost update view, kind = 1
	typedef struct packed {
		logic                 kind;
		logic [6:0]           pad;
		logic [q_w-1:0]       cost;
		logic [cluster_w-1:0] src_cluster;
		logic [node_id_w-1:0] src_id;
	} update_view_t;

	// route request view, kind = 0
	typedef struct packed {
		logic                 kind;
		logic [26:0]          pad;
		logic [node_id_w-1:0] dest_id;
	} request_view_t;

	// one message word, decoded by kind
	typedef union packed {
		update_view_t  upd;
		request_view_t req;
	} route_msg_u;

endpackage

//--- source/qroute_top.sv
`timescale 1ns/1ps

module qroute_top #(
	parameter int alpha_shift = 2,
	parameter int table_depth = 16
) (
	input  logic        clock,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready
);
	import qroute_pkg::*;

	// config and message fields
	logic [node_id_w-1:0] my_id, msg_id;
	logic [cluster_w-1:0] my_cluster, msg_cluster;
	logic [7:0]           epsilon;
	logic                 msg_start, msg_update;
	logic [q_w-1:0]       msg_cost;

	// learner and table port a
	logic [node_id_w-1:0] rd_a_id, wr_id;
	logic                 wr_en, learn_done, rd_a_valid;
	logic [cluster_w-1:0] wr_cluster;
	logic [q_w-1:0]       wr_q, rd_a_q;

	// search, policy and table port b
	logic [node_id_w-1:0] scan_id, probe_id, rd_b_id, best_id, next_hop;
	logic                 search_done, best_valid, policy_done, rd_b_valid;
	logic [cluster_w-1:0] rd_b_cluster;
	logic [q_w-1:0]       rd_b_q;
	logic [1:0]           action;

	// port b goes to the policy only in its single cycle
	assign rd_b_id = search_done ? probe_id : scan_id;

	apb_node_regs u_regs (
		.clock, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.my_id, .my_cluster, .epsilon, .msg_start, .msg_update, .msg_id,
		.msg_cluster, .msg_cost, .learn_done, .policy_done, .action, .next_hop
	);

	neighbor_table #(.table_depth(table_depth)) u_table (
		.clock, .rst, .wr_en, .wr_id, .wr_cluster, .wr_q,
		.rd_a_id, .rd_b_id, .rd_a_valid, .rd_a_cluster(), .rd_a_q,
		.rd_b_valid, .rd_b_cluster, .rd_b_q
	);

	cost_learner #(.alpha_shift(alpha_shift)) u_learn (
		.clock, .rst, .msg_start, .msg_update, .msg_id, .msg_cluster, .msg_cost,
		.rd_id(rd_a_id), .wr_en, .wr_id, .wr_cluster, .wr_q, .learn_done,
		.rd_valid(rd_a_valid), .rd_q(rd_a_q)
	);

	// best cost stays inside the search stage
	best_search #(.table_depth(table_depth)) u_search (
		.clock, .rst, .msg_start, .msg_update, .my_cluster, .scan_id,
		.search_done, .best_valid, .best_id, .best_q(),
		.scan_valid(rd_b_valid), .scan_cluster(rd_b_cluster), .scan_q(rd_b_q)
	);

	hop_policy u_policy (
		.clock, .rst, .search_done, .best_valid, .best_id, .my_id, .epsilon, .msg_id,
		.probe_id, .probe_valid(rd_b_valid), .probe_cluster(rd_b_cluster),
		.my_cluster, .policy_done, .action, .next_hop
	);

endmodule
